// File: all.f
verilog/datapath_pkg.sv
verilog/uop_pkg.sv
verilog/reg_file.sv
verilog/operand_read.sv
verilog/alu.sv
verilog/exec_writeback.sv
verilog/exec_cluster.sv
bench/tb_clock.sv
bench/exec_cluster_sva.sv
bench/exec_cluster_tb.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exec_cluster_tb -f all.f -o exec_cluster_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/exec_cluster_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1

// File: bench/exec_cluster_tb.sv
module exec_cluster_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int STALL_BOUND = 40;    // cycles allowed per row under random back-pressure.
    localparam int RANDOM_ROWS = 40;

    typedef struct packed {
        uop_pkg::alu_ctrl_t     ctrl;
        datapath_pkg::reg_idx_t rs0;
        datapath_pkg::reg_idx_t rs1;
        logic                   use_imm;
        datapath_pkg::word_t    imm;
        datapath_pkg::reg_idx_t rd;
        logic                   wen;
    } row_t;

    typedef struct packed {
        datapath_pkg::reg_idx_t rd;
        logic                   wen;
        datapath_pkg::word_t    result;
    } expect_t;

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    logic                   in_ready;
    uop_pkg::alu_ctrl_t     in_ctrl;
    datapath_pkg::reg_idx_t in_rs0;
    datapath_pkg::reg_idx_t in_rs1;
    logic                   in_use_imm;
    datapath_pkg::word_t    in_imm;
    datapath_pkg::reg_idx_t in_rd;
    logic                   in_wen;
    logic                   out_valid;
    logic                   out_ready;
    datapath_pkg::reg_idx_t out_rd;
    logic                   out_wen;
    datapath_pkg::word_t    out_result;

    row_t                rows[$];
    expect_t             expected_q[$];
    datapath_pkg::word_t model_regs [32];
    int                  received;
    logic                random_sink;
    logic                table_ready;

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

    exec_cluster #(.NUM_REGS(32)) dut (.*);

    function automatic datapath_pkg::word_t alu_model(input uop_pkg::alu_ctrl_t ctrl,
                                                      input datapath_pkg::word_t a,
                                                      input datapath_pkg::word_t b);
        logic [datapath_pkg::SHAMT_BITS-1:0] sh;
        sh = a[datapath_pkg::SHAMT_BITS-1:0];    // only the low bits of sr0 count.
        case (ctrl)
            uop_pkg::CTRL_ALU_ADD:  return a + b;
            uop_pkg::CTRL_ALU_SUB:  return a - b;
            uop_pkg::CTRL_ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            uop_pkg::CTRL_ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            uop_pkg::CTRL_ALU_AND:  return a & b;
            uop_pkg::CTRL_ALU_OR:   return a | b;
            uop_pkg::CTRL_ALU_NOR:  return ~(a | b);
            uop_pkg::CTRL_ALU_XOR:  return a ^ b;
            uop_pkg::CTRL_ALU_SLL:  return b << sh;
            uop_pkg::CTRL_ALU_SRL:  return b >> sh;
            uop_pkg::CTRL_ALU_SRA:  return $unsigned($signed(b) >>> sh);
            default:                return '0;
        endcase
    endfunction

    // rows are modelled in issue order, which is also the order of the register writes.
    task automatic add_row(input uop_pkg::alu_ctrl_t ctrl, input datapath_pkg::reg_idx_t rs0,
                           input datapath_pkg::reg_idx_t rs1, input logic use_imm,
                           input datapath_pkg::word_t imm, input datapath_pkg::reg_idx_t rd,
                           input logic wen);
        expect_t             want;
        datapath_pkg::word_t sr0;
        datapath_pkg::word_t sr1;
        sr1 = model_regs[rs1];
        sr0 = use_imm ? imm : model_regs[rs0];
        want = '{rd, wen, alu_model(ctrl, sr0, sr1)};
        rows.push_back('{ctrl, rs0, rs1, use_imm, imm, rd, wen});
        expected_q.push_back(want);
        if (wen && rd != 5'd0)
            model_regs[rd] = want.result;
    endtask

    task automatic build_table();
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd5,  1'b0, 32'h0,         5'd9,  1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd0,  1'b1, 32'h8000_0000, 5'd1,  1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd0,  1'b1, 32'h7fff_ffff, 5'd2,  1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd0,  1'b1, 32'hffff_ffff, 5'd3,  1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd0,  1'b1, 32'h0000_0005, 5'd4,  1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd0,  1'b1, 32'h0000_003f, 5'd5,  1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd0,  1'b1, 32'h1234_5678, 5'd6,  1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd0,  1'b1, 32'hf0f0_f0f0, 5'd7,  1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd1,  1'b0, 32'h0,         5'd8,  1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd2,  1'b0, 32'h0,         5'd8,  1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd3,  1'b0, 32'h0,         5'd8,  1'b1);
        add_row(uop_pkg::CTRL_ALU_SUB,  5'd4,  5'd2,  1'b0, 32'h0,         5'd9,  1'b1);
        add_row(uop_pkg::CTRL_ALU_SUB,  5'd0,  5'd4,  1'b1, 32'h0000_0003, 5'd9,  1'b1);
        add_row(uop_pkg::CTRL_ALU_SLT,  5'd1,  5'd2,  1'b0, 32'h0,         5'd10, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SLT,  5'd2,  5'd1,  1'b0, 32'h0,         5'd10, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SLT,  5'd3,  5'd4,  1'b0, 32'h0,         5'd10, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SLTU, 5'd1,  5'd2,  1'b0, 32'h0,         5'd10, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SLTU, 5'd4,  5'd3,  1'b0, 32'h0,         5'd10, 1'b1);
        add_row(uop_pkg::CTRL_ALU_AND,  5'd6,  5'd7,  1'b0, 32'h0,         5'd11, 1'b1);
        add_row(uop_pkg::CTRL_ALU_OR,   5'd6,  5'd7,  1'b0, 32'h0,         5'd11, 1'b1);
        add_row(uop_pkg::CTRL_ALU_NOR,  5'd6,  5'd7,  1'b0, 32'h0,         5'd11, 1'b1);
        add_row(uop_pkg::CTRL_ALU_XOR,  5'd0,  5'd7,  1'b1, 32'h0000_ffff, 5'd11, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SLL,  5'd0,  5'd6,  1'b1, 32'h0,         5'd11, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SLL,  5'd5,  5'd4,  1'b0, 32'h0,         5'd11, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SLL,  5'd0,  5'd6,  1'b1, 32'h0000_0021, 5'd11, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SRL,  5'd0,  5'd3,  1'b1, 32'h0000_001f, 5'd11, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SRA,  5'd0,  5'd1,  1'b1, 32'h0000_001f, 5'd11, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SRA,  5'd0,  5'd7,  1'b1, 32'h0000_0004, 5'd11, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SRA,  5'd0,  5'd1,  1'b0, 32'h0,         5'd11, 1'b1);
        add_row(4'd11,                  5'd3,  5'd3,  1'b0, 32'h0,         5'd11, 1'b1);
        add_row(4'd15,                  5'd0,  5'd3,  1'b1, 32'hffff_ffff, 5'd11, 1'b1);
        // dependent chain, each row reads the previous destination.
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd0,  1'b1, 32'h0000_0001, 5'd12, 1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd12, 5'd12, 1'b0, 32'h0,         5'd12, 1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd12, 5'd12, 1'b0, 32'h0,         5'd12, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SUB,  5'd12, 5'd4,  1'b0, 32'h0,         5'd13, 1'b1);
        add_row(uop_pkg::CTRL_ALU_XOR,  5'd13, 5'd12, 1'b0, 32'h0,         5'd12, 1'b1);
        add_row(uop_pkg::CTRL_ALU_SLL,  5'd4,  5'd12, 1'b0, 32'h0,         5'd12, 1'b1);
        // a clear write enable and a write to register 0 must leave nothing behind.
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd0,  1'b1, 32'hdead_beef, 5'd6,  1'b0);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd6,  1'b0, 32'h0,         5'd14, 1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd0,  1'b1, 32'h0000_0055, 5'd0,  1'b1);
        add_row(uop_pkg::CTRL_ALU_ADD,  5'd0,  5'd0,  1'b0, 32'h0,         5'd15, 1'b1);
        for (int n = 0; n < RANDOM_ROWS; n++)
            add_row(4'($urandom % 16), 5'($urandom % 16), 5'($urandom % 16), 1'($urandom),
                    $urandom, 5'($urandom % 16), 1'($urandom));
    endtask

    task automatic check_value(input string what, input datapath_pkg::word_t got,
                               input datapath_pkg::word_t want);
        if (got !== want) begin
            $display("Error: time %0t: %s is %h, expected %h", $time, what, got, want);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic compare_output();
        expect_t want;
        if (expected_q.size() == 0) begin
            $display("Output transfer at time %0t with no result left to expect", $time);
            $display("Regression failed");
            $fatal(1, "unexpected output transfer");
        end
        want = expected_q.pop_front();
        check_value("out_rd", 32'(out_rd), 32'(want.rd));
        check_value("out_wen", 32'(out_wen), 32'(want.wen));
        check_value("out_result", out_result, want.result);
        received++;
    endtask

    initial begin
        void'($urandom(32'h5e46_b22f));
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_ctrl     = '0;
        in_rs0      = '0;
        in_rs1      = '0;
        in_use_imm  = 1'b0;
        in_imm      = '0;
        in_rd       = '0;
        in_wen      = 1'b0;
        random_sink = 1'b0;
        received    = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_value("out_valid after reset", 32'(out_valid), 32'd0);
        check_value("in_ready after reset", 32'(in_ready), 32'd1);
        for (int i = 0; i < rows.size(); i++) begin
            if (i == rows.size() - RANDOM_ROWS)
                random_sink = 1'b1;
            @(negedge clk);
            in_valid   = 1'b1;
            in_ctrl    = rows[i].ctrl;
            in_rs0     = rows[i].rs0;
            in_rs1     = rows[i].rs1;
            in_use_imm = rows[i].use_imm;
            in_imm     = rows[i].imm;
            in_rd      = rows[i].rd;
            in_wen     = rows[i].wen;
            #1;
            if (!random_sink)
                check_value("in_ready with a free sink", 32'(in_ready), 32'd1);
            while (!in_ready) begin
                @(negedge clk);
                #1;
            end
            @(posedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
        wait (received == rows.size());
        repeat (2) @(negedge clk);
        if (expected_q.size() == 0 && !out_valid) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Results left over or an extra output after the last row");
            $display("Regression failed");
            $fatal(1, "end of run mismatch");
        end
    end

    // the sink decides at the falling edge, so a transfer is known before the rising edge.
    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (random_sink)
                out_ready = ($urandom % 4) != 0;
            else
                out_ready = 1'b1;
            if (!reset && out_valid && out_ready)
                compare_output();
        end
    end

    initial begin
        wait (table_ready);
        #((rows.size() * STALL_BOUND + 20) * CLK_PERIOD);
        $display("Timeout: %0d of %0d results arrived before the time limit", received,
                 rows.size());
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: bench/exec_cluster_sva.sv
module exec_cluster_sva (
    input logic                   clk,
    input logic                   reset,
    input logic                   in_valid,
    input logic                   in_ready,
    input logic                   out_valid,
    input logic                   out_ready,
    input datapath_pkg::reg_idx_t out_rd,
    input logic                   out_wen,
    input datapath_pkg::word_t    out_result
);

    // a stalled result keeps every field until the sink takes it.
    out_fields_stable_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_rd) && $stable(out_wen)
                                    && $stable(out_result)
    ) else $error("output stream changed while stalled");

    // the micro-op sits one cycle in the operand stage, so a free sink sees it the cycle after.
    out_valid_two_cycles_after_accept: assert property (
        @(posedge clk) disable iff (reset)
        $past(in_valid && in_ready) && out_ready |=> out_valid
    ) else $error("out_valid missing two cycles after an accept");

    reset_clears_out_valid: assert property (
        @(posedge clk) reset |=> !out_valid
    ) else $error("out_valid high after reset");

endmodule

bind exec_cluster exec_cluster_sva u_sva (.*);

// File: bench/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: verilog/exec_cluster.sv
module exec_cluster #(
    parameter int NUM_REGS = 32
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   in_valid,
    output logic                   in_ready,
    input  uop_pkg::alu_ctrl_t     in_ctrl,
    input  datapath_pkg::reg_idx_t in_rs0,
    input  datapath_pkg::reg_idx_t in_rs1,
    input  logic                   in_use_imm,
    input  datapath_pkg::word_t    in_imm,
    input  datapath_pkg::reg_idx_t in_rd,
    input  logic                   in_wen,

    output logic                   out_valid,
    input  logic                   out_ready,
    output datapath_pkg::reg_idx_t out_rd,
    output logic                   out_wen,
    output datapath_pkg::word_t    out_result
);
    datapath_pkg::reg_idx_t rd_addr0;
    datapath_pkg::reg_idx_t rd_addr1;
    datapath_pkg::word_t    rd_data0;
    datapath_pkg::word_t    rd_data1;

    uop_pkg::alu_ctrl_t     alu_ctrl;
    datapath_pkg::word_t    alu_sr0;
    datapath_pkg::word_t    alu_sr1;
    datapath_pkg::word_t    alu_result;

    logic                   ex_valid;
    datapath_pkg::reg_idx_t ex_rd;
    logic                   ex_wen;
    logic                   wb_ready;

    logic                   rf_we;
    datapath_pkg::reg_idx_t rf_waddr;
    datapath_pkg::word_t    rf_wdata;

    operand_read u_operand_read (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_ctrl    (in_ctrl),
        .in_rs0     (in_rs0),
        .in_rs1     (in_rs1),
        .in_use_imm (in_use_imm),
        .in_imm     (in_imm),
        .in_rd      (in_rd),
        .in_wen     (in_wen),
        .rd_addr0   (rd_addr0),
        .rd_addr1   (rd_addr1),
        .rd_data0   (rd_data0),
        .rd_data1   (rd_data1),
        .alu_ctrl   (alu_ctrl),
        .alu_sr0    (alu_sr0),
        .alu_sr1    (alu_sr1),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_wen     (ex_wen),
        .wb_ready   (wb_ready)
    );

    alu u_alu (
        .alu_control (alu_ctrl),
        .alu_sr0     (alu_sr0),
        .alu_sr1     (alu_sr1),
        .alu_result  (alu_result)
    );

    exec_writeback u_exec_writeback (
        .clk        (clk),
        .reset      (reset),
        .ex_valid   (ex_valid),
        .ex_rd      (ex_rd),
        .ex_wen     (ex_wen),
        .ex_result  (alu_result),
        .wb_ready   (wb_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_rd     (out_rd),
        .out_wen    (out_wen),
        .out_result (out_result),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .raddr0 (rd_addr0),
        .raddr1 (rd_addr1),
        .rdata0 (rd_data0),
        .rdata1 (rd_data1),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

// File: verilog/exec_writeback.sv
module exec_writeback (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   ex_valid,
    input  datapath_pkg::reg_idx_t ex_rd,
    input  logic                   ex_wen,
    input  datapath_pkg::word_t    ex_result,
    output logic                   wb_ready,

    output logic                   out_valid,
    input  logic                   out_ready,
    output datapath_pkg::reg_idx_t out_rd,
    output logic                   out_wen,
    output datapath_pkg::word_t    out_result,

    output logic                   rf_we,
    output datapath_pkg::reg_idx_t rf_waddr,
    output datapath_pkg::word_t    rf_wdata
);
    logic capture;

    // the slot frees up in the same cycle that the consumer takes the result.
    assign wb_ready = !out_valid || out_ready;
    assign capture  = ex_valid && wb_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (capture) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            out_rd     <= ex_rd;
            out_wen    <= ex_wen;
            out_result <= ex_result;
        end
    end

    // the register file is written on the capture edge, so the next
    // micro-op in the operand stage already reads the new value.
    assign rf_we    = capture && ex_wen;
    assign rf_waddr = ex_rd;
    assign rf_wdata = ex_result;

endmodule

// File: verilog/alu.sv
module alu (
    input  uop_pkg::alu_ctrl_t  alu_control,
    input  datapath_pkg::word_t alu_sr0,
    input  datapath_pkg::word_t alu_sr1,
    output datapath_pkg::word_t alu_result
);
    localparam int W = datapath_pkg::DATA_BITS;

    logic op_add;
    logic op_sub;
    logic op_slt;
    logic op_sltu;
    logic op_and;
    logic op_or;
    logic op_nor;
    logic op_xor;
    logic op_sll;
    logic op_srl;
    logic op_sra;

    assign op_add  = alu_control == uop_pkg::CTRL_ALU_ADD;
    assign op_sub  = alu_control == uop_pkg::CTRL_ALU_SUB;
    assign op_slt  = alu_control == uop_pkg::CTRL_ALU_SLT;
    assign op_sltu = alu_control == uop_pkg::CTRL_ALU_SLTU;
    assign op_and  = alu_control == uop_pkg::CTRL_ALU_AND;
    assign op_or   = alu_control == uop_pkg::CTRL_ALU_OR;
    assign op_nor  = alu_control == uop_pkg::CTRL_ALU_NOR;
    assign op_xor  = alu_control == uop_pkg::CTRL_ALU_XOR;
    assign op_sll  = alu_control == uop_pkg::CTRL_ALU_SLL;
    assign op_srl  = alu_control == uop_pkg::CTRL_ALU_SRL;
    assign op_sra  = alu_control == uop_pkg::CTRL_ALU_SRA;

    logic                               do_sub;
    datapath_pkg::word_t                adder_b;
    logic [W:0]                         adder_sum;
    datapath_pkg::word_t                adder_result;
    logic                               adder_cout;
    logic                               slt_bit;
    logic [datapath_pkg::SHAMT_BITS-1:0] shamt;

    // subtraction and both compares reuse the adder as sr0 + ~sr1 + 1.
    assign do_sub       = op_sub | op_slt | op_sltu;
    assign adder_b      = do_sub ? ~alu_sr1 : alu_sr1;
    assign adder_sum    = {1'b0, alu_sr0} + {1'b0, adder_b} + {{W{1'b0}}, do_sub};
    assign adder_result = adder_sum[W-1:0];
    assign adder_cout   = adder_sum[W];

    // differing signs decide at once, otherwise the sign of the difference does.
    assign slt_bit = (alu_sr0[W-1] & ~alu_sr1[W-1])
                   | (~(alu_sr0[W-1] ^ alu_sr1[W-1]) & adder_result[W-1]);

    assign shamt = alu_sr0[datapath_pkg::SHAMT_BITS-1:0];

    datapath_pkg::word_t slt_result;
    datapath_pkg::word_t sltu_result;
    datapath_pkg::word_t sra_result;

    assign slt_result  = {{(W-1){1'b0}}, slt_bit};
    assign sltu_result = {{(W-1){1'b0}}, ~adder_cout};    // no carry out means a borrow.
    assign sra_result  = $signed(alu_sr1) >>> shamt;

    // an unused code matches no decode and leaves the result at zero.
    assign alu_result = ({W{op_add | op_sub}} & adder_result)
                      | ({W{op_slt}}          & slt_result)
                      | ({W{op_sltu}}         & sltu_result)
                      | ({W{op_and}}          & (alu_sr0 & alu_sr1))
                      | ({W{op_or}}           & (alu_sr0 | alu_sr1))
                      | ({W{op_nor}}          & ~(alu_sr0 | alu_sr1))
                      | ({W{op_xor}}          & (alu_sr0 ^ alu_sr1))
                      | ({W{op_sll}}          & (alu_sr1 << shamt))
                      | ({W{op_srl}}          & (alu_sr1 >> shamt))
                      | ({W{op_sra}}          & sra_result);

endmodule

// File: verilog/operand_read.sv
module operand_read (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   in_valid,
    output logic                   in_ready,
    input  uop_pkg::alu_ctrl_t     in_ctrl,
    input  datapath_pkg::reg_idx_t in_rs0,
    input  datapath_pkg::reg_idx_t in_rs1,
    input  logic                   in_use_imm,
    input  datapath_pkg::word_t    in_imm,
    input  datapath_pkg::reg_idx_t in_rd,
    input  logic                   in_wen,

    output datapath_pkg::reg_idx_t rd_addr0,
    output datapath_pkg::reg_idx_t rd_addr1,
    input  datapath_pkg::word_t    rd_data0,
    input  datapath_pkg::word_t    rd_data1,

    output uop_pkg::alu_ctrl_t     alu_ctrl,
    output datapath_pkg::word_t    alu_sr0,
    output datapath_pkg::word_t    alu_sr1,

    output logic                   ex_valid,
    output datapath_pkg::reg_idx_t ex_rd,
    output logic                   ex_wen,
    input  logic                   wb_ready
);
    logic full;

    uop_pkg::alu_ctrl_t     ctrl_q;
    datapath_pkg::reg_idx_t rs0_q;
    datapath_pkg::reg_idx_t rs1_q;
    logic                   use_imm_q;
    datapath_pkg::word_t    imm_q;
    datapath_pkg::reg_idx_t rd_q;
    logic                   wen_q;

    logic accept;
    logic advance;

    assign advance  = full && wb_ready;     // the held micro-op moves to writeback.
    assign in_ready = !full || wb_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (accept) begin
            full <= 1'b1;
        end else if (advance) begin
            full <= 1'b0;
        end
    end

    // the micro-op fields need no reset, full qualifies them.
    always_ff @(posedge clk) begin
        if (accept) begin
            ctrl_q    <= in_ctrl;
            rs0_q     <= in_rs0;
            rs1_q     <= in_rs1;
            use_imm_q <= in_use_imm;
            imm_q     <= in_imm;
            rd_q      <= in_rd;
            wen_q     <= in_wen;
        end
    end

    // operands are read while the micro-op sits here, so a stall picks up later writes.
    assign rd_addr0 = rs0_q;
    assign rd_addr1 = rs1_q;

    assign alu_ctrl = ctrl_q;
    assign alu_sr0  = use_imm_q ? imm_q : rd_data0;    // the immediate replaces rs0.
    assign alu_sr1  = rd_data1;

    assign ex_valid = full;
    assign ex_rd    = rd_q;
    assign ex_wen   = wen_q;

endmodule

// File: verilog/reg_file.sv
module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  datapath_pkg::reg_idx_t raddr0,
    input  datapath_pkg::reg_idx_t raddr1,
    output datapath_pkg::word_t    rdata0,
    output datapath_pkg::word_t    rdata1,
    input  logic                   we,
    input  datapath_pkg::reg_idx_t waddr,
    input  datapath_pkg::word_t    wdata
);
    localparam int IDX_BITS = $clog2(NUM_REGS);

    datapath_pkg::word_t regs [NUM_REGS];

    logic [IDX_BITS-1:0] ridx0;
    logic [IDX_BITS-1:0] ridx1;
    logic [IDX_BITS-1:0] widx;

    // with a smaller file the upper index bits are simply dropped.
    assign ridx0 = raddr0[IDX_BITS-1:0];
    assign ridx1 = raddr1[IDX_BITS-1:0];
    assign widx  = waddr[IDX_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && widx != '0) begin     // register 0 is hardwired.
            regs[widx] <= wdata;
        end
    end

    // reads are combinational so a value written at an edge is seen right after it.
    assign rdata0 = (ridx0 == '0) ? '0 : regs[ridx0];
    assign rdata1 = (ridx1 == '0) ? '0 : regs[ridx1];

endmodule

// File: verilog/uop_pkg.sv
package uop_pkg;

    localparam int CTRL_BITS = 4;

    typedef logic [CTRL_BITS-1:0] alu_ctrl_t;

    // arithmetic group, all served by the one adder.
    localparam alu_ctrl_t CTRL_ALU_ADD  = 4'd0;
    localparam alu_ctrl_t CTRL_ALU_SUB  = 4'd1;
    localparam alu_ctrl_t CTRL_ALU_SLT  = 4'd2;
    localparam alu_ctrl_t CTRL_ALU_SLTU = 4'd3;

    // bitwise logic.
    localparam alu_ctrl_t CTRL_ALU_AND  = 4'd4;
    localparam alu_ctrl_t CTRL_ALU_OR   = 4'd5;
    localparam alu_ctrl_t CTRL_ALU_NOR  = 4'd6;
    localparam alu_ctrl_t CTRL_ALU_XOR  = 4'd7;

    // shifts move sr1 by the amount in sr0.
    localparam alu_ctrl_t CTRL_ALU_SLL  = 4'd8;
    localparam alu_ctrl_t CTRL_ALU_SRL  = 4'd9;
    localparam alu_ctrl_t CTRL_ALU_SRA  = 4'd10;

    // codes 11 to 15 are unused and give a zero result.

endpackage

// File: verilog/datapath_pkg.sv
package datapath_pkg;

    // width of one data word in the integer datapath.
    localparam int DATA_BITS = 32;

    // 32 architectural registers need a 5-bit index.
    localparam int REG_IDX_BITS = 5;

    // only the low bits of sr0 take part in a shift.
    localparam int SHAMT_BITS = 5;

    typedef logic [DATA_BITS-1:0] word_t;     // one register or result value.

    typedef logic [REG_IDX_BITS-1:0] reg_idx_t;    // register number.

endpackage
